/* hdl/npu_pkg.sv */
/*
 * shared widths, control words and enums for the NPU instruction path
 * referenced by scoped names from every RTL block
 */
package npu_pkg;

	//////////////////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////////////////

	// one 32-bit part as it arrives from the command side
	typedef logic [31:0] inst_part_t;

	// full instruction, first part received lands in the top word
	typedef logic [127:0] npu_inst_t;

	// run length in clock cycles
	typedef logic [31:0] inst_time_t;

	// fixed framing, four parts per instruction
	localparam int PARTS_PER_INST = 4;

	//////////////////////////////////////////////////////////////
	// control words
	//////////////////////////////////////////////////////////////

	// whole-word compare, any other value is a program word
	localparam npu_inst_t INST_CLEAR_WORD = 128'd1;
	localparam npu_inst_t INST_START_WORD = 128'd2;

	typedef enum logic [1:0] {
		INST_STORE,
		INST_CLEAR,
		INST_START
	} inst_kind_e;

	//////////////////////////////////////////////////////////////
	// operating modes from the switch code
	//////////////////////////////////////////////////////////////

	// MODE_NONE stands for every code not listed
	typedef enum logic [4:0] {
		MODE_NONE = 5'b00000,
		MODE_SAMP = 5'b00011,
		MODE_SIMU = 5'b01000,
		MODE_RUN  = 5'b01001,
		MODE_TEST = 5'b10100
	} npu_mode_e;

	// issue sequencer states
	typedef enum logic [1:0] {
		ISSUE_IDLE,
		ISSUE_READ,
		ISSUE_HOLD,
		ISSUE_DONE
	} issue_state_e;

endpackage

/* hdl/npu_inst_join.sv */
/*
 * joins four 32-bit parts into one 128-bit instruction
 * a partial instruction is dropped after JOIN_TIMEOUT idle cycles
 */
`timescale 1ns/1ps

module npu_inst_join #(
	parameter int JOIN_TIMEOUT = 64
) (
	input  logic                npu_inst_clk,
	input  logic                rst_n,
	input  npu_pkg::inst_part_t inst_part,
	input  logic                inst_part_en,
	output npu_pkg::npu_inst_t  inst,
	output logic                inst_en
);

	localparam int CNT_W  = $clog2(npu_pkg::PARTS_PER_INST);
	localparam int IDLE_W = $clog2(JOIN_TIMEOUT + 1);
	localparam int PART_W = $bits(npu_pkg::inst_part_t);
	localparam int INST_W = $bits(npu_pkg::npu_inst_t);

	npu_pkg::npu_inst_t shift_q;
	logic [CNT_W-1:0]   part_cnt;
	logic [IDLE_W-1:0]  idle_cnt;
	logic               last_part;
	logic               pending;

	// fourth part closes the instruction
	assign last_part = (part_cnt == CNT_W'(npu_pkg::PARTS_PER_INST - 1));
	// some parts held, waiting for the rest
	assign pending   = (part_cnt != '0);

	//////////////////////////////////////////////////////////////
	// payload shift register
	//////////////////////////////////////////////////////////////

	// older parts move up, so the first one ends as the top word
	always_ff @(posedge npu_inst_clk) begin
		if (inst_part_en) begin
			shift_q <= {shift_q[INST_W-PART_W-1:0], inst_part};
		end
	end

	assign inst = shift_q;

	//////////////////////////////////////////////////////////////
	// part count and idle timeout
	//////////////////////////////////////////////////////////////

	always_ff @(posedge npu_inst_clk or negedge rst_n) begin
		if (!rst_n) begin
			part_cnt <= '0;
			idle_cnt <= '0;
			inst_en  <= 1'b0;
		end else begin
			inst_en <= 1'b0;
			if (inst_part_en) begin
				idle_cnt <= '0;
				if (last_part) begin
					part_cnt <= '0;
					inst_en  <= 1'b1;
				end else begin
					part_cnt <= part_cnt + 1'b1;
				end
			end else if (pending) begin
				// gap too long, throw the partial word away
				if (idle_cnt == IDLE_W'(JOIN_TIMEOUT)) begin
					part_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	// an instruction needs four strobes, so two back to back pulses mean a broken count
	a_inst_en_single: assert property (@(posedge npu_inst_clk) disable iff (!rst_n)
		inst_en |=> !inst_en);

endmodule

/* hdl/npu_inst_store.sv */
/*
 * decodes clear and start control words and keeps the program in a RAM
 * write side fed by the join stage, read side by the issue sequencer
 */
`timescale 1ns/1ps

module npu_inst_store #(
	parameter int INST_ADDR_W = 6
) (
	input  logic                   npu_inst_clk,
	input  logic                   rst_n,
	input  npu_pkg::npu_inst_t     inst,
	input  logic                   inst_en,
	input  logic [INST_ADDR_W-1:0] rd_addr,
	output npu_pkg::npu_inst_t     rd_data,
	output logic [INST_ADDR_W:0]   inst_count,
	output logic                   ctrl_start
);

	localparam int DEPTH = 1 << INST_ADDR_W;

	npu_pkg::npu_inst_t   ram [DEPTH];
	npu_pkg::inst_kind_e  kind;
	logic [INST_ADDR_W:0] wr_ptr;
	logic                 full;
	logic                 do_store;

	// whole-word decode, control words never reach the RAM
	always_comb begin
		if (inst == npu_pkg::INST_CLEAR_WORD) begin
			kind = npu_pkg::INST_CLEAR;
		end else if (inst == npu_pkg::INST_START_WORD) begin
			kind = npu_pkg::INST_START;
		end else begin
			kind = npu_pkg::INST_STORE;
		end
	end

	assign full     = (wr_ptr == (INST_ADDR_W + 1)'(DEPTH));
	assign do_store = inst_en && (kind == npu_pkg::INST_STORE) && !full;

	//////////////////////////////////////////////////////////////
	// write pointer and start strobe
	//////////////////////////////////////////////////////////////

	always_ff @(posedge npu_inst_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			ctrl_start <= 1'b0;
		end else begin
			ctrl_start <= inst_en && (kind == npu_pkg::INST_START);
			if (inst_en && (kind == npu_pkg::INST_CLEAR)) begin
				wr_ptr <= '0;
			end else if (do_store) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	assign inst_count = wr_ptr;

	//////////////////////////////////////////////////////////////
	// instruction RAM, synchronous read
	//////////////////////////////////////////////////////////////

	always_ff @(posedge npu_inst_clk) begin
		if (do_store) begin
			ram[wr_ptr[INST_ADDR_W-1:0]] <= inst;
		end
		rd_data <= ram[rd_addr];
	end

	// program longer than the RAM, the sender has to clear first
	a_no_overflow: assert property (@(posedge npu_inst_clk) disable iff (!rst_n)
		(inst_en && kind == npu_pkg::INST_STORE) |-> !full);

endmodule

/* hdl/npu_start_ctrl.sv */
/*
 * picks the start source from the switch mode code
 * test mode uses control word or key 3, run and simulation use the VAD start
 */
`timescale 1ns/1ps

module npu_start_ctrl (
	input  logic       npu_inst_clk,
	input  logic       rst_n,
	input  logic [4:0] sw_mode,
	input  logic       key3,
	input  logic       start_vad,
	input  logic       ctrl_start,
	output logic       start
);

	npu_pkg::npu_mode_e mode;
	logic [1:0]         key_sync;
	logic               key_press;
	logic               start_sel;

	// unlisted codes fall into no mode
	always_comb begin
		case (sw_mode)
			npu_pkg::MODE_TEST: mode = npu_pkg::MODE_TEST;
			npu_pkg::MODE_SAMP: mode = npu_pkg::MODE_SAMP;
			npu_pkg::MODE_RUN:  mode = npu_pkg::MODE_RUN;
			npu_pkg::MODE_SIMU: mode = npu_pkg::MODE_SIMU;
			default:            mode = npu_pkg::MODE_NONE;
		endcase
	end

	// key is active low, idle level high out of reset
	always_ff @(posedge npu_inst_clk or negedge rst_n) begin
		if (!rst_n) begin
			key_sync <= 2'b11;
		end else begin
			key_sync <= {key_sync[0], key3};
		end
	end

	// falling edge = press
	assign key_press = (key_sync == 2'b10);

	// only the source of the current mode counts
	always_comb begin
		case (mode)
			npu_pkg::MODE_TEST: start_sel = ctrl_start || key_press;
			npu_pkg::MODE_RUN,
			npu_pkg::MODE_SIMU: start_sel = start_vad;
			default:            start_sel = 1'b0;
		endcase
	end

	always_ff @(posedge npu_inst_clk or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
		end else begin
			start <= start_sel;
		end
	end

endmodule

/* hdl/npu_inst_issue.sv */
/*
 * reads the stored program in address order and hands it out on valid/ready
 * reports the busy cycle count of each run in inst_time
 */
`timescale 1ns/1ps

module npu_inst_issue #(
	parameter int INST_ADDR_W = 6
) (
	input  logic                   npu_inst_clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic [INST_ADDR_W:0]   inst_count,
	output logic [INST_ADDR_W-1:0] rd_addr,
	input  npu_pkg::npu_inst_t     rd_data,
	output npu_pkg::npu_inst_t     inst_out,
	output logic                   inst_valid,
	input  logic                   inst_ready,
	output logic                   busy,
	output logic                   done,
	output npu_pkg::inst_time_t    inst_time
);

	npu_pkg::issue_state_e state;
	npu_pkg::inst_time_t   busy_cnt;
	logic [INST_ADDR_W:0]  run_count;
	logic [INST_ADDR_W:0]  next_idx;
	logic                  last_inst;

	// index after the current one, compared against the latched length
	assign next_idx  = {1'b0, rd_addr} + 1'b1;
	assign last_inst = (next_idx == run_count);

	//////////////////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////////////////

	always_ff @(posedge npu_inst_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= npu_pkg::ISSUE_IDLE;
			rd_addr   <= '0;
			run_count <= '0;
			busy_cnt  <= '0;
			inst_time <= '0;
		end else begin
			case (state)
				npu_pkg::ISSUE_IDLE: begin
					// empty program, start is ignored
					if (start && (inst_count != '0)) begin
						state     <= npu_pkg::ISSUE_READ;
						rd_addr   <= '0;
						run_count <= inst_count;
						busy_cnt  <= '0;
					end
				end
				npu_pkg::ISSUE_READ: begin
					// RAM output lands next cycle
					state    <= npu_pkg::ISSUE_HOLD;
					busy_cnt <= busy_cnt + 1'b1;
				end
				npu_pkg::ISSUE_HOLD: begin
					busy_cnt <= busy_cnt + 1'b1;
					if (inst_ready) begin
						if (last_inst) begin
							state     <= npu_pkg::ISSUE_DONE;
							inst_time <= busy_cnt + 1'b1;
						end else begin
							state   <= npu_pkg::ISSUE_READ;
							rd_addr <= rd_addr + 1'b1;
						end
					end
				end
				npu_pkg::ISSUE_DONE: begin
					state <= npu_pkg::ISSUE_IDLE;
				end
				default: begin
					state <= npu_pkg::ISSUE_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////
	// outputs decoded from the state
	//////////////////////////////////////////////////////////////

	// address held while stalled, so the RAM output stays put
	assign inst_out   = rd_data;
	assign inst_valid = (state == npu_pkg::ISSUE_HOLD);
	assign busy       = (state == npu_pkg::ISSUE_READ) || (state == npu_pkg::ISSUE_HOLD);
	assign done       = (state == npu_pkg::ISSUE_DONE);

	// stalled word must not change until the consumer takes it
	a_hold_stable: assert property (@(posedge npu_inst_clk) disable iff (!rst_n)
		(inst_valid && !inst_ready) |=> (inst_valid && $stable(inst_out)));

endmodule

/* hdl/npu_inst_top.sv */
/*
 * instruction path top, parts in and issued NPU instructions out
 * sets RAM depth and join timeout for the blocks below
 */
`timescale 1ns/1ps

module npu_inst_top #(
	parameter int INST_ADDR_W  = 6,
	parameter int JOIN_TIMEOUT = 64
) (
	input  logic                npu_inst_clk,
	input  logic                rst_n,
	input  npu_pkg::inst_part_t inst_part,
	input  logic                inst_part_en,
	input  logic [4:0]          sw_mode,
	input  logic                key3,
	input  logic                start_vad,
	output npu_pkg::npu_inst_t  inst_out,
	output logic                inst_valid,
	input  logic                inst_ready,
	output logic                busy,
	output logic                done,
	output npu_pkg::inst_time_t inst_time
);

	// joined instruction
	npu_pkg::npu_inst_t     inst;
	logic                   inst_en;
	// RAM read side
	logic [INST_ADDR_W-1:0] rd_addr;
	npu_pkg::npu_inst_t     rd_data;
	logic [INST_ADDR_W:0]   inst_count;
	// start path
	logic                   ctrl_start;
	logic                   start;

	//////////////////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////////////////

	npu_inst_join #(
		.JOIN_TIMEOUT (JOIN_TIMEOUT)
	) u_npu_inst_join (
		.npu_inst_clk (npu_inst_clk),
		.rst_n        (rst_n),
		.inst_part    (inst_part),
		.inst_part_en (inst_part_en),
		.inst         (inst),
		.inst_en      (inst_en)
	);

	npu_inst_store #(
		.INST_ADDR_W (INST_ADDR_W)
	) u_npu_inst_store (
		.npu_inst_clk (npu_inst_clk),
		.rst_n        (rst_n),
		.inst         (inst),
		.inst_en      (inst_en),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.inst_count   (inst_count),
		.ctrl_start   (ctrl_start)
	);

	//////////////////////////////////////////////////////////////
	// start select and issue
	//////////////////////////////////////////////////////////////

	npu_start_ctrl u_npu_start_ctrl (
		.npu_inst_clk (npu_inst_clk),
		.rst_n        (rst_n),
		.sw_mode      (sw_mode),
		.key3         (key3),
		.start_vad    (start_vad),
		.ctrl_start   (ctrl_start),
		.start        (start)
	);

	npu_inst_issue #(
		.INST_ADDR_W (INST_ADDR_W)
	) u_npu_inst_issue (
		.npu_inst_clk (npu_inst_clk),
		.rst_n        (rst_n),
		.start        (start),
		.inst_count   (inst_count),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.inst_out     (inst_out),
		.inst_valid   (inst_valid),
		.inst_ready   (inst_ready),
		.busy         (busy),
		.done         (done),
		.inst_time    (inst_time)
	);

endmodule

/* verif/tb_clk_gen.sv */
/*
 * testbench clock and reset source
 * free-running clock, rst_n released after RST_CYCLES rising edges
 */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 4,
	parameter int RST_CYCLES = 8
) (
	output logic npu_inst_clk,
	output logic rst_n
);

	initial begin
		npu_inst_clk = 1'b0;
		forever #(PERIOD_NS / 2) npu_inst_clk = ~npu_inst_clk;
	end

	// release just after an edge, away from DUT sampling
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge npu_inst_clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

/* verif/tb_npu_inst_checks.svh */
/*
 * compare tasks and LCG helper, included inside the testbench top module
 * mismatches print a FAIL line and end the run through halt_run
 */
`ifndef TB_NPU_INST_CHECKS_SVH
`define TB_NPU_INST_CHECKS_SVH

	// 32-bit LCG step, full period constants
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// one issued instruction against the model
	task automatic check_inst(input npu_pkg::npu_inst_t got, input npu_pkg::npu_inst_t want,
			input string what);
		if (got !== want) begin
			$display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, want);
			halt_run();
		end
	endtask

	// run length or busy cycle count
	task automatic check_time(input npu_pkg::inst_time_t got, input npu_pkg::inst_time_t want,
			input string what);
		if (got !== want) begin
			$display("FAIL at %0t ns: %s got %0d expected %0d", $time, what, got, want);
			halt_run();
		end
	endtask

	// number of transfers seen on the output handshake
	task automatic check_count(input int got, input int want, input string what);
		if (got != want) begin
			$display("FAIL at %0t ns: %s got %0d expected %0d", $time, what, got, want);
			halt_run();
		end
	endtask

`endif

/* verif/tb_npu_inst.sv */
/*
 * testbench for the NPU instruction path top
 * applies a table of load/start scenarios and checks the issued program and run time
 */
`timescale 1ns/1ps

module tb_npu_inst;

	localparam int INST_ADDR_W  = 6;
	localparam int JOIN_TIMEOUT = 64;
	localparam int CLK_PERIOD   = 4;
	localparam int PART_W       = $bits(npu_pkg::inst_part_t);
	localparam int NUM_ROWS     = 11;
	localparam logic [31:0] LCG_SEED = 32'he3598858;

	typedef enum logic [1:0] {SRC_WORD, SRC_KEY, SRC_VAD} start_src_e;

	// stall is 0..3, inst_ready low with chance stall/4
	typedef struct packed {
		logic [4:0]  mode;
		logic        clear;
		int          len;
		logic [31:0] seed;
		int          stray;
		start_src_e  src;
		int          stall;
		logic        expect_run;
	} row_t;

	row_t rows [NUM_ROWS] = '{
		'{5'b10100, 1'b1, 6,  32'h0000a001, 0, SRC_WORD, 0, 1'b1},  // plain test run
		'{5'b10100, 1'b1, 10, 32'h0000b002, 0, SRC_WORD, 2, 1'b1},  // back-pressure
		'{5'b10100, 1'b1, 5,  32'h0000c003, 3, SRC_WORD, 1, 1'b1},  // stray parts dropped
		'{5'b01001, 1'b1, 7,  32'h0000d004, 0, SRC_WORD, 0, 1'b0},  // run mode, word ignored
		'{5'b01001, 1'b0, 0,  32'h0,        0, SRC_KEY,  0, 1'b0},  // run mode, key ignored
		'{5'b01001, 1'b0, 0,  32'h0,        0, SRC_VAD,  3, 1'b1},  // run mode, vad starts
		'{5'b00011, 1'b0, 0,  32'h0,        0, SRC_VAD,  0, 1'b0},  // sampling never starts
		'{5'b10100, 1'b0, 0,  32'h0,        0, SRC_KEY,  1, 1'b1},  // key reissues program
		'{5'b10100, 1'b1, 3,  32'h0000e005, 0, SRC_WORD, 2, 1'b1},  // shorter reload
		'{5'b01000, 1'b0, 0,  32'h0,        0, SRC_VAD,  0, 1'b1},  // simulation mode
		'{5'b11111, 1'b0, 0,  32'h0,        0, SRC_VAD,  0, 1'b0}   // unknown code
	};

	logic                npu_inst_clk;
	logic                rst_n;
	npu_pkg::inst_part_t inst_part;
	logic                inst_part_en;
	logic [4:0]          sw_mode;
	logic                key3;
	logic                start_vad;
	npu_pkg::npu_inst_t  inst_out;
	logic                inst_valid;
	logic                inst_ready;
	logic                busy;
	logic                done;
	npu_pkg::inst_time_t inst_time;

	// reference program and what came out
	npu_pkg::npu_inst_t  model [$];
	npu_pkg::npu_inst_t  issued [$];
	npu_pkg::inst_time_t busy_cycles = '0;
	int                  done_count  = 0;
	int                  stall_rate  = 0;
	logic [31:0]         word_state;
	logic [31:0]         ready_state;

	`include "tb_npu_inst_checks.svh"

	tb_clk_gen #(
		.PERIOD_NS  (CLK_PERIOD),
		.RST_CYCLES (8)
	) u_tb_clk_gen (
		.npu_inst_clk (npu_inst_clk),
		.rst_n        (rst_n)
	);

	npu_inst_top #(
		.INST_ADDR_W  (INST_ADDR_W),
		.JOIN_TIMEOUT (JOIN_TIMEOUT)
	) u_npu_inst_top (
		.npu_inst_clk (npu_inst_clk),
		.rst_n        (rst_n),
		.inst_part    (inst_part),
		.inst_part_en (inst_part_en),
		.sw_mode      (sw_mode),
		.key3         (key3),
		.start_vad    (start_vad),
		.inst_out     (inst_out),
		.inst_valid   (inst_valid),
		.inst_ready   (inst_ready),
		.busy         (busy),
		.done         (done),
		.inst_time    (inst_time)
	);

	task automatic halt_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	//////////////////////////////////////////////////////////////
	// drivers, all changes 1 ns after the rising edge
	//////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge npu_inst_clk);
		#1;
	endtask

	task automatic send_part(input npu_pkg::inst_part_t part);
		inst_part    = part;
		inst_part_en = 1'b1;
		next_cycle();
	endtask

	// top word goes first
	task automatic send_word(input npu_pkg::npu_inst_t w);
		for (int p = 0; p < npu_pkg::PARTS_PER_INST; p++) begin
			send_part(w[127 - PART_W * p -: PART_W]);
		end
		inst_part_en = 1'b0;
	endtask

	// random program word, never a control value
	task automatic make_word(output npu_pkg::npu_inst_t w);
		w = '0;
		for (int p = 0; p < npu_pkg::PARTS_PER_INST; p++) begin
			word_state = lcg_next(word_state);
			w = {w[127 - PART_W:0], word_state};
		end
		if (w == npu_pkg::INST_CLEAR_WORD || w == npu_pkg::INST_START_WORD) begin
			w[127] = 1'b1;
		end
	endtask

	// partial word, then a gap past the join timeout
	task automatic drop_stray_parts(input int count);
		npu_pkg::npu_inst_t junk;
		make_word(junk);
		for (int p = 0; p < count; p++) begin
			send_part(junk[127 - PART_W * p -: PART_W]);
		end
		inst_part_en = 1'b0;
		repeat (JOIN_TIMEOUT + 8) next_cycle();
	endtask

	task automatic start_run(input start_src_e src);
		case (src)
			SRC_WORD: send_word(npu_pkg::INST_START_WORD);
			SRC_KEY: begin
				// held long enough to clear both sync flops
				key3 = 1'b0;
				repeat (4) next_cycle();
				key3 = 1'b1;
			end
			default: begin
				start_vad = 1'b1;
				next_cycle();
				start_vad = 1'b0;
			end
		endcase
	endtask

	task automatic wait_for_done(input int base_done, input int words);
		int waited;
		waited = 0;
		while (done_count == base_done) begin
			if (waited > words * 64 + 64) begin
				$display("no done pulse within %0d cycles after the start", waited);
				halt_run();
			end
			next_cycle();
			waited++;
		end
	endtask

	// random back-pressure
	initial begin
		inst_ready  = 1'b0;
		ready_state = LCG_SEED;
		forever begin
			@(posedge npu_inst_clk);
			#1;
			ready_state = lcg_next(ready_state);
			inst_ready  = (int'(ready_state[31:30]) >= stall_rate);
		end
	end

	//////////////////////////////////////////////////////////////
	// monitor, sampled mid-cycle
	//////////////////////////////////////////////////////////////

	always @(negedge npu_inst_clk) begin
		if (rst_n) begin
			if (busy) begin
				busy_cycles = busy_cycles + 32'd1;
			end
			// transfer lands on the next rising edge
			if (inst_valid && inst_ready) begin
				issued.push_back(inst_out);
			end
			if (done) begin
				done_count++;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// scenario loop
	//////////////////////////////////////////////////////////////

	initial begin : main_seq
		npu_pkg::npu_inst_t  w;
		int                  base_issued;
		int                  base_done;
		npu_pkg::inst_time_t base_busy;
		inst_part    = '0;
		inst_part_en = 1'b0;
		sw_mode      = 5'b00000;
		key3         = 1'b1;
		start_vad    = 1'b0;
		word_state   = LCG_SEED;
		@(posedge rst_n);
		next_cycle();
		for (int r = 0; r < NUM_ROWS; r++) begin
			sw_mode    = rows[r].mode;
			word_state = lcg_next(LCG_SEED ^ rows[r].seed);
			next_cycle();
			if (rows[r].clear) begin
				send_word(npu_pkg::INST_CLEAR_WORD);
				model.delete();
			end
			if (rows[r].stray > 0) begin
				drop_stray_parts(rows[r].stray);
			end
			for (int i = 0; i < rows[r].len; i++) begin
				make_word(w);
				send_word(w);
				model.push_back(w);
			end
			stall_rate  = rows[r].stall;
			base_issued = issued.size();
			base_busy   = busy_cycles;
			base_done   = done_count;
			start_run(rows[r].src);
			if (rows[r].expect_run) begin
				wait_for_done(base_done, model.size());
				check_count(issued.size() - base_issued, model.size(), "issued count");
				for (int i = 0; i < model.size(); i++) begin
					check_inst(issued[base_issued + i], model[i], "issued word");
				end
				check_time(inst_time, busy_cycles - base_busy, "inst_time");
			end else begin
				// quiet window, nothing may start
				repeat (3 * JOIN_TIMEOUT) next_cycle();
				check_count(issued.size() - base_issued, 0, "issued count without start");
				check_time(busy_cycles - base_busy, '0, "busy cycles without start");
			end
		end
		$display("Regression passed");
		$finish;
	end

	// watchdog, budget scales with program length and stall rate
	initial begin : watchdog
		longint limit_cycles;
		limit_cycles = 64;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit_cycles += (rows[r].len + 16) * (rows[r].stall * 4 + 8) + 4 * JOIN_TIMEOUT;
		end
		#(limit_cycles * CLK_PERIOD);
		$display("run hung, still going after %0d cycles", limit_cycles);
		halt_run();
	end

endmodule

/* verilog.f */
+incdir+verif
hdl/npu_pkg.sv
hdl/npu_inst_join.sv
hdl/npu_inst_store.sv
hdl/npu_start_ctrl.sv
hdl/npu_inst_issue.sv
hdl/npu_inst_top.sv
verif/tb_clk_gen.sv
verif/tb_npu_inst.sv

/* run_sim.sh */
#!/bin/sh
# build and run the NPU instruction path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_npu_inst \
	-o tb_npu_inst

./obj_dir/tb_npu_inst
